//--- decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int ilen       = 32;
    localparam int reg_addr_w = 5;
    localparam int uop_w      = 6;

    //////////////////////////////
    // base opcodes
    localparam logic [6:0] opc_op       = 7'b01_100_11;
    localparam logic [6:0] opc_op_imm   = 7'b00_100_11;
    localparam logic [6:0] opc_auipc    = 7'b00_101_11;
    localparam logic [6:0] opc_jal      = 7'b11_011_11;
    localparam logic [6:0] opc_jalr     = 7'b11_001_11;
    localparam logic [6:0] opc_branch   = 7'b11_000_11;
    localparam logic [6:0] opc_lui      = 7'b01_101_11;
    localparam logic [6:0] opc_load     = 7'b00_000_11;
    localparam logic [6:0] opc_store    = 7'b01_000_11;
    localparam logic [6:0] opc_misc_mem = 7'b00_011_11;
    localparam logic [6:0] opc_system   = 7'b11_100_11;

    // funct7 variants seen under the op opcode
    localparam logic [6:0] funct7_base   = 7'b0000000;
    localparam logic [6:0] funct7_alt    = 7'b0100000;
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    //////////////////////////////
    // one instruction word, six views
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic [6:0]            imm7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm5;
            logic [6:0]            opcode;
        } s;
        // branch offset kept in the store layout, bit 0 implied
        struct packed {
            logic [6:0]            imm7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm5;
            logic [6:0]            opcode;
        } b;
        struct packed {
            logic [19:0]           imm20;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } u;
        struct packed {
            logic [19:0]           imm20;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } j;
    } instr_t;

    //////////////////////////////
    // decode result codes
    typedef enum logic [3:0] {
        cls_op_r, cls_op_mul, cls_op_div, cls_op_imm, cls_auipc, cls_jal, cls_jalr,
        cls_branch, cls_lui, cls_load, cls_store, cls_misc_mem, cls_system, cls_illegal
    } op_class_t;

    typedef enum logic [2:0] {
        fmt_r = 3'd0,
        fmt_i = 3'd1,
        fmt_s = 3'd2,
        fmt_b = 3'd3,
        fmt_u = 3'd4,
        fmt_j = 3'd5
    } fmt_t;

    typedef enum logic [2:0] {
        xpipe = 3'd0,
        dpipe = 3'd1,
        lpipe = 3'd2,
        cpipe = 3'd3
    } pipe_t;

endpackage

`default_nettype wire

//--- instr_latch.sv
`default_nettype none

module instr_latch #(
    parameter int xlen = 32
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          stall,
    input  wire                          clear,
    input  wire  [decode_pkg::ilen-1:0]  instr,
    input  wire  [xlen-1:0]              pc,
    output decode_pkg::instr_t           held,
    output logic [xlen-1:0]              held_pc,
    output logic                         valid
);

    // fetch to decode register
    // clear wins over stall, a flushed slot reads as a zero word
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            held    <= '0;
            held_pc <= '0;
            valid   <= 1'b0;
        end else if (!stall) begin
            held    <= instr;
            held_pc <= pc;
            valid   <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- op_classify.sv
`default_nettype none

module op_classify (
    input  wire decode_pkg::instr_t   held,
    output decode_pkg::op_class_t     op_class,
    output decode_pkg::fmt_t          fmt,
    output decode_pkg::pipe_t         pipe
);

    //////////////////////////////
    // opcode class
    always_comb begin
        case (held.r.opcode)
            decode_pkg::opc_op: begin
                if (held.r.funct7 == decode_pkg::funct7_base ||
                    held.r.funct7 == decode_pkg::funct7_alt) begin
                    op_class = decode_pkg::cls_op_r;
                end else if (held.r.funct7 == decode_pkg::funct7_muldiv) begin
                    // funct3 4..7 are the divide/remainder ops
                    op_class = (held.r.funct3 < 3'd4) ? decode_pkg::cls_op_mul
                                                      : decode_pkg::cls_op_div;
                end else begin
                    op_class = decode_pkg::cls_illegal;
                end
            end
            decode_pkg::opc_op_imm:   op_class = decode_pkg::cls_op_imm;
            decode_pkg::opc_auipc:    op_class = decode_pkg::cls_auipc;
            decode_pkg::opc_jal:      op_class = decode_pkg::cls_jal;
            decode_pkg::opc_jalr:     op_class = decode_pkg::cls_jalr;
            decode_pkg::opc_branch:   op_class = decode_pkg::cls_branch;
            decode_pkg::opc_lui:      op_class = decode_pkg::cls_lui;
            decode_pkg::opc_load:     op_class = decode_pkg::cls_load;
            decode_pkg::opc_store:    op_class = decode_pkg::cls_store;
            decode_pkg::opc_misc_mem: op_class = decode_pkg::cls_misc_mem;
            decode_pkg::opc_system:   op_class = decode_pkg::cls_system;
            default:                  op_class = decode_pkg::cls_illegal;
        endcase
    end

    //////////////////////////////
    // encoding format and issue pipe, both from the class
    always_comb begin
        case (op_class)
            decode_pkg::cls_op_imm, decode_pkg::cls_jalr, decode_pkg::cls_lui,
            decode_pkg::cls_load, decode_pkg::cls_misc_mem,
            decode_pkg::cls_system: fmt = decode_pkg::fmt_i;
            decode_pkg::cls_store:  fmt = decode_pkg::fmt_s;
            decode_pkg::cls_branch: fmt = decode_pkg::fmt_b;
            decode_pkg::cls_auipc:  fmt = decode_pkg::fmt_u;
            decode_pkg::cls_jal:    fmt = decode_pkg::fmt_j;
            // op classes and illegal words
            default:                fmt = decode_pkg::fmt_r;
        endcase
    end

    always_comb begin
        case (op_class)
            decode_pkg::cls_op_div: pipe = decode_pkg::dpipe;
            decode_pkg::cls_lui, decode_pkg::cls_load, decode_pkg::cls_store,
            decode_pkg::cls_misc_mem: pipe = decode_pkg::lpipe;
            decode_pkg::cls_system: pipe = decode_pkg::cpipe;
            default:                pipe = decode_pkg::xpipe;
        endcase
    end

endmodule

`default_nettype wire

//--- uop_encode.sv
`default_nettype none

module uop_encode (
    input  wire decode_pkg::instr_t      held,
    input  wire decode_pkg::op_class_t   op_class,
    input  wire decode_pkg::pipe_t       pipe,
    output logic [decode_pkg::uop_w-1:0] uop
);

    logic [2:0] grp;
    logic [2:0] idx;
    logic [2:0] funct3;
    logic       alt_shift;

    assign funct3 = held.r.funct3;

    // srai: funct3 5 with the alt pattern in the upper immediate bits
    assign alt_shift = (held.i.funct3 == 3'd5) &&
                       (held.i.imm12[11:5] == decode_pkg::funct7_alt);

    // uop is a 3-bit group over a 3-bit index, group meaning depends on pipe
    always_comb begin
        grp = 3'd7;
        idx = 3'd7;
        case (pipe)
            decode_pkg::xpipe: begin
                case (op_class)
                    decode_pkg::cls_op_r: begin
                        if (held.r.funct7 == decode_pkg::funct7_base) begin
                            grp = 3'd0;
                            idx = funct3;
                        end else begin
                            // sub or sra
                            grp = 3'd1;
                            idx = (funct3 == 3'd0) ? 3'd4 : 3'd5;
                        end
                    end
                    decode_pkg::cls_op_mul: begin
                        grp = 3'd1;
                        idx = funct3;
                    end
                    decode_pkg::cls_op_imm: begin
                        grp = alt_shift ? 3'd3 : 3'd2;
                        idx = alt_shift ? 3'd2 : funct3;
                    end
                    decode_pkg::cls_branch: begin
                        grp = 3'd3;
                        idx = funct3;
                    end
                    decode_pkg::cls_auipc: begin
                        grp = 3'd4;
                        idx = 3'd0;
                    end
                    decode_pkg::cls_jal: begin
                        grp = 3'd4;
                        idx = 3'd1;
                    end
                    decode_pkg::cls_jalr: begin
                        grp = 3'd4;
                        idx = 3'd2;
                    end
                    default: begin
                        grp = 3'd7;
                        idx = 3'd7;
                    end
                endcase
            end
            decode_pkg::dpipe: begin
                grp = 3'd0;
                idx = funct3;
            end
            decode_pkg::lpipe: begin
                case (op_class)
                    decode_pkg::cls_load: begin
                        grp = 3'd0;
                        idx = funct3;
                    end
                    decode_pkg::cls_lui: begin
                        grp = 3'd0;
                        idx = 3'd3;
                    end
                    decode_pkg::cls_store: begin
                        grp = 3'd1;
                        idx = funct3;
                    end
                    decode_pkg::cls_misc_mem: begin
                        grp = 3'd2;
                        idx = funct3;
                    end
                    default: begin
                        grp = 3'd7;
                        idx = 3'd7;
                    end
                endcase
            end
            decode_pkg::cpipe: begin
                if (funct3 == 3'd0) begin
                    // ecall vs ebreak
                    grp = 3'd0;
                    idx = (held.i.imm12 == 12'd1) ? 3'd1 : 3'd0;
                end else begin
                    grp = 3'd1;
                    idx = funct3;
                end
            end
            default: begin
                grp = 3'd7;
                idx = 3'd7;
            end
        endcase
    end

    assign uop = {grp, idx};

endmodule

`default_nettype wire

//--- operand_select.sv
`default_nettype none

module operand_select #(
    parameter int xlen = 32
) (
    input  wire decode_pkg::instr_t           held,
    input  wire decode_pkg::op_class_t        op_class,
    input  wire decode_pkg::fmt_t             fmt,
    output logic [decode_pkg::reg_addr_w-1:0] rd_addr,
    output logic [decode_pkg::reg_addr_w-1:0] rs_addr,
    output logic [decode_pkg::reg_addr_w-1:0] rt_addr,
    output logic                              req_rs,
    output logic                              req_rt,
    output logic [xlen-1:0]                   imm,
    output logic [xlen-1:0]                   base
);

    logic        sys;
    logic        sys_rs;
    logic        sys_no_rs;
    logic        rd_used;
    logic        rs_used;
    logic        rt_used;
    logic [19:0] imm_raw;

    // csrrw/csrrs/csrrc read rs1, the others carry a zimm there
    assign sys       = (op_class == decode_pkg::cls_system);
    assign sys_rs    = sys && (held.i.funct3 >= 3'd1) && (held.i.funct3 <= 3'd3);
    assign sys_no_rs = sys && !sys_rs;

    //////////////////////////////
    // register usage per format
    assign rd_used = (fmt == decode_pkg::fmt_r) || (fmt == decode_pkg::fmt_i) ||
                     (fmt == decode_pkg::fmt_u) || (fmt == decode_pkg::fmt_j);
    assign rs_used = (fmt == decode_pkg::fmt_r) || (fmt == decode_pkg::fmt_s) ||
                     (fmt == decode_pkg::fmt_b) ||
                     ((fmt == decode_pkg::fmt_i) && !sys_no_rs);
    assign rt_used = (fmt == decode_pkg::fmt_r) || (fmt == decode_pkg::fmt_s) ||
                     (fmt == decode_pkg::fmt_b);

    assign rd_addr = rd_used ? held.r.rd  : '0;
    assign rs_addr = rs_used ? held.r.rs1 : '0;
    assign rt_addr = rt_used ? held.r.rs2 : '0;
    assign req_rs  = rs_used;
    assign req_rt  = rt_used;

    //////////////////////////////
    // raw immediate field, zero-extended to xlen
    always_comb begin
        case (fmt)
            decode_pkg::fmt_i: begin
                if (sys_no_rs) begin
                    imm_raw = {3'b000, held.i.imm12, held.i.rs1};
                end else begin
                    imm_raw = {8'h00, held.i.imm12};
                end
            end
            decode_pkg::fmt_s: imm_raw = {8'h00, held.s.imm7, held.s.imm5};
            decode_pkg::fmt_b: imm_raw = {7'h00, held.b.imm7, held.b.imm5, 1'b0};
            decode_pkg::fmt_u: imm_raw = held.u.imm20;
            decode_pkg::fmt_j: imm_raw = held.j.imm20;
            default:           imm_raw = '0;
        endcase
    end

    assign imm = xlen'(imm_raw);

    // memory base offset, low 12 bits hold the load or store offset
    always_comb begin
        case (op_class)
            decode_pkg::cls_load,
            decode_pkg::cls_store: base = xlen'($signed(imm_raw[11:0]));
            decode_pkg::cls_lui:   base = xlen'({held.u.imm20, 12'h000});
            default:               base = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- decode_stage.sv
`default_nettype none

module decode_stage #(
    parameter int xlen = 32
) (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire  [decode_pkg::ilen-1:0]       instr,
    input  wire  [xlen-1:0]                   pc,
    input  wire                               stall,
    input  wire                               clear,
    output logic                              valid,
    output logic [xlen-1:0]                   pc_out,
    output decode_pkg::pipe_t                 uop_pipe,
    output logic [decode_pkg::uop_w-1:0]      uop,
    output logic [decode_pkg::reg_addr_w-1:0] rd_addr,
    output logic [decode_pkg::reg_addr_w-1:0] rs_addr,
    output logic [decode_pkg::reg_addr_w-1:0] rt_addr,
    output logic                              req_rs,
    output logic                              req_rt,
    output logic [xlen-1:0]                   imm,
    output logic [xlen-1:0]                   base
);

    decode_pkg::instr_t    held;
    decode_pkg::op_class_t op_class;
    decode_pkg::fmt_t      fmt;

    //////////////////////////////
    // register, then combinational decode off the held word
    instr_latch #(.xlen(xlen)) u_instr_latch (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .clear   (clear),
        .instr   (instr),
        .pc      (pc),
        .held    (held),
        .held_pc (pc_out),
        .valid   (valid)
    );

    op_classify u_op_classify (
        .held     (held),
        .op_class (op_class),
        .fmt      (fmt),
        .pipe     (uop_pipe)
    );

    uop_encode u_uop_encode (
        .held     (held),
        .op_class (op_class),
        .pipe     (uop_pipe),
        .uop      (uop)
    );

    operand_select #(.xlen(xlen)) u_operand_select (
        .held     (held),
        .op_class (op_class),
        .fmt      (fmt),
        .rd_addr  (rd_addr),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .req_rs   (req_rs),
        .req_rt   (req_rt),
        .imm      (imm),
        .base     (base)
    );

endmodule

`default_nettype wire

//--- decode_chk.sv
`default_nettype none

module decode_chk #(
    parameter int xlen = 32
) (
    input wire                          clk,
    input wire                          rst_n,
    input wire                          stall,
    input wire                          clear,
    input wire                          valid,
    input wire [xlen-1:0]               pc_out,
    input wire [decode_pkg::uop_w-1:0]  uop,
    input wire                          req_rs,
    input wire                          req_rt
);

    timeunit 1ns;
    timeprecision 1ps;

    // flushed slot is never valid
    valid_low_after_flush: assert property (@(posedge clk) (!rst_n || clear) |=> !valid)
        else $error("valid high one cycle after clear or reset");

    //////////////////////////////
    // stall keeps the stage frozen
    hold_on_stall: assert property (@(posedge clk)
        (rst_n && stall && !clear) |=> ($stable(pc_out) && $stable(uop)))
        else $error("pc_out or uop changed across a stall");

    rt_needs_rs: assert property (@(posedge clk) req_rt |-> req_rs)
        else $error("req_rt raised without req_rs");

endmodule

bind decode_stage decode_chk #(.xlen(xlen)) u_decode_chk (
    .clk    (clk),
    .rst_n  (rst_n),
    .stall  (stall),
    .clear  (clear),
    .valid  (valid),
    .pc_out (pc_out),
    .uop    (uop),
    .req_rs (req_rs),
    .req_rt (req_rt)
);

`default_nettype wire

//--- tb_decode_stage.sv
`default_nettype none

module tb_decode_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int xlen         = 32;
    localparam int reset_cycles = 5;
    localparam int num_cycles   = 2000;
    // generous margin over the stimulus length plus reset
    localparam int max_cycles   = num_cycles + num_cycles / 4;

    logic                              clk = 1'b0;
    logic                              rst_n;
    logic [decode_pkg::ilen-1:0]       instr;
    logic [xlen-1:0]                   pc;
    logic                              stall;
    logic                              clear;
    logic                              valid;
    logic [xlen-1:0]                   pc_out;
    decode_pkg::pipe_t                 uop_pipe;
    logic [decode_pkg::uop_w-1:0]      uop;
    logic [decode_pkg::reg_addr_w-1:0] rd_addr;
    logic [decode_pkg::reg_addr_w-1:0] rs_addr;
    logic [decode_pkg::reg_addr_w-1:0] rt_addr;
    logic                              req_rs;
    logic                              req_rt;
    logic [xlen-1:0]                   imm;
    logic [xlen-1:0]                   base;

    // reference copy of the decode register
    logic [31:0]     m_held;
    logic [xlen-1:0] m_pc;
    logic            m_valid;
    int              cycle_count = 0;

    decode_stage #(.xlen(xlen)) u_decode_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .pc       (pc),
        .stall    (stall),
        .clear    (clear),
        .valid    (valid),
        .pc_out   (pc_out),
        .uop_pipe (uop_pipe),
        .uop      (uop),
        .rd_addr  (rd_addr),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .req_rs   (req_rs),
        .req_rt   (req_rt),
        .imm      (imm),
        .base     (base)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: stimulus still running after %0d cycles", cycle_count);
            $display("Verification failed");
            $fatal(1, "cycle limit reached");
        end
    end

    //////////////////////////////
    // error reporting and compare tasks

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
        $display("Verification failed");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic check_uop(input decode_pkg::pipe_t exp_pipe, input decode_pkg::pipe_t act_pipe,
                             input logic [decode_pkg::uop_w-1:0] exp_uop,
                             input logic [decode_pkg::uop_w-1:0] act_uop);
        if (act_pipe !== exp_pipe)
            report_mismatch("uop_pipe", 64'(exp_pipe), 64'(act_pipe));
        else if (act_uop !== exp_uop)
            report_mismatch("uop", 64'(exp_uop), 64'(act_uop));
    endtask

    task automatic check_addr(input string name, input logic [decode_pkg::reg_addr_w-1:0] exp,
                              input logic [decode_pkg::reg_addr_w-1:0] act);
        if (act !== exp)
            report_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] exp,
                              input logic [xlen-1:0] act);
        if (act !== exp)
            report_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_mismatch(name, 64'(exp), 64'(act));
    endtask

    //////////////////////////////
    // reference decode, straight from the bit layout

    function automatic decode_pkg::op_class_t model_class(input logic [31:0] w);
        logic [6:0] f7;
        f7 = w[31:25];
        case (w[6:0])
            decode_pkg::opc_op: begin
                if (f7 == decode_pkg::funct7_base || f7 == decode_pkg::funct7_alt)
                    return decode_pkg::cls_op_r;
                else if (f7 == decode_pkg::funct7_muldiv)
                    return (w[14:12] < 3'd4) ? decode_pkg::cls_op_mul : decode_pkg::cls_op_div;
                else
                    return decode_pkg::cls_illegal;
            end
            decode_pkg::opc_op_imm:   return decode_pkg::cls_op_imm;
            decode_pkg::opc_auipc:    return decode_pkg::cls_auipc;
            decode_pkg::opc_jal:      return decode_pkg::cls_jal;
            decode_pkg::opc_jalr:     return decode_pkg::cls_jalr;
            decode_pkg::opc_branch:   return decode_pkg::cls_branch;
            decode_pkg::opc_lui:      return decode_pkg::cls_lui;
            decode_pkg::opc_load:     return decode_pkg::cls_load;
            decode_pkg::opc_store:    return decode_pkg::cls_store;
            decode_pkg::opc_misc_mem: return decode_pkg::cls_misc_mem;
            decode_pkg::opc_system:   return decode_pkg::cls_system;
            default:                  return decode_pkg::cls_illegal;
        endcase
    endfunction

    function automatic decode_pkg::fmt_t model_fmt(input decode_pkg::op_class_t c);
        case (c)
            decode_pkg::cls_op_imm, decode_pkg::cls_jalr, decode_pkg::cls_lui,
            decode_pkg::cls_load, decode_pkg::cls_misc_mem,
            decode_pkg::cls_system: return decode_pkg::fmt_i;
            decode_pkg::cls_store:  return decode_pkg::fmt_s;
            decode_pkg::cls_branch: return decode_pkg::fmt_b;
            decode_pkg::cls_auipc:  return decode_pkg::fmt_u;
            decode_pkg::cls_jal:    return decode_pkg::fmt_j;
            default:                return decode_pkg::fmt_r;
        endcase
    endfunction

    function automatic decode_pkg::pipe_t model_pipe(input decode_pkg::op_class_t c);
        case (c)
            decode_pkg::cls_op_div:   return decode_pkg::dpipe;
            decode_pkg::cls_lui, decode_pkg::cls_load, decode_pkg::cls_store,
            decode_pkg::cls_misc_mem: return decode_pkg::lpipe;
            decode_pkg::cls_system:   return decode_pkg::cpipe;
            default:                  return decode_pkg::xpipe;
        endcase
    endfunction

    // group in the upper three bits, index in the lower three
    function automatic logic [5:0] model_uop(input logic [31:0] w,
                                             input decode_pkg::op_class_t c);
        logic [2:0] f3;
        f3 = w[14:12];
        case (c)
            decode_pkg::cls_op_r: begin
                if (w[31:25] == decode_pkg::funct7_base)
                    return {3'd0, f3};
                else
                    return {3'd1, (f3 == 3'd0) ? 3'd4 : 3'd5};
            end
            decode_pkg::cls_op_mul:   return {3'd1, f3};
            decode_pkg::cls_op_div:   return {3'd0, f3};
            decode_pkg::cls_op_imm: begin
                if (f3 == 3'd5 && w[31:25] == decode_pkg::funct7_alt)
                    return {3'd3, 3'd2};
                else
                    return {3'd2, f3};
            end
            decode_pkg::cls_branch:   return {3'd3, f3};
            decode_pkg::cls_auipc:    return {3'd4, 3'd0};
            decode_pkg::cls_jal:      return {3'd4, 3'd1};
            decode_pkg::cls_jalr:     return {3'd4, 3'd2};
            decode_pkg::cls_load:     return {3'd0, f3};
            decode_pkg::cls_lui:      return {3'd0, 3'd3};
            decode_pkg::cls_store:    return {3'd1, f3};
            decode_pkg::cls_misc_mem: return {3'd2, f3};
            decode_pkg::cls_system: begin
                if (f3 == 3'd0)
                    return {3'd0, (w[31:20] == 12'd1) ? 3'd1 : 3'd0};
                else
                    return {3'd1, f3};
            end
            default:                  return {3'd7, 3'd7};
        endcase
    endfunction

    task automatic check_outputs();
        decode_pkg::op_class_t cls;
        decode_pkg::fmt_t      fm;
        logic [2:0]            f3;
        logic                  sys_no_rs;
        logic                  rd_use;
        logic                  rs_use;
        logic                  rt_use;
        logic [11:0]           off;
        logic [xlen-1:0]       exp_imm;
        logic [xlen-1:0]       exp_base;
        cls       = model_class(m_held);
        fm        = model_fmt(cls);
        f3        = m_held[14:12];
        sys_no_rs = (cls == decode_pkg::cls_system) && !(f3 >= 3'd1 && f3 <= 3'd3);
        rd_use    = (fm == decode_pkg::fmt_r) || (fm == decode_pkg::fmt_i) ||
                    (fm == decode_pkg::fmt_u) || (fm == decode_pkg::fmt_j);
        rt_use    = (fm == decode_pkg::fmt_r) || (fm == decode_pkg::fmt_s) ||
                    (fm == decode_pkg::fmt_b);
        rs_use    = rt_use || ((fm == decode_pkg::fmt_i) && !sys_no_rs);
        case (fm)
            decode_pkg::fmt_i: begin
                if (sys_no_rs)
                    exp_imm = xlen'({m_held[31:20], m_held[19:15]});
                else
                    exp_imm = xlen'(m_held[31:20]);
            end
            decode_pkg::fmt_s: exp_imm = xlen'({m_held[31:25], m_held[11:7]});
            decode_pkg::fmt_b: exp_imm = xlen'({m_held[31:25], m_held[11:7], 1'b0});
            decode_pkg::fmt_u, decode_pkg::fmt_j: exp_imm = xlen'(m_held[31:12]);
            default:           exp_imm = '0;
        endcase
        // load and store offsets sit in different bits
        off = (cls == decode_pkg::cls_load) ? m_held[31:20] : {m_held[31:25], m_held[11:7]};
        if (cls == decode_pkg::cls_load || cls == decode_pkg::cls_store)
            exp_base = {{(xlen-12){off[11]}}, off};
        else if (cls == decode_pkg::cls_lui)
            exp_base = xlen'({m_held[31:12], 12'h000});
        else
            exp_base = '0;
        check_bit("valid", m_valid, valid);
        check_word("pc_out", m_pc, pc_out);
        check_uop(model_pipe(cls), uop_pipe, model_uop(m_held, cls), uop);
        check_addr("rd_addr", rd_use ? m_held[11:7] : 5'd0, rd_addr);
        check_addr("rs_addr", rs_use ? m_held[19:15] : 5'd0, rs_addr);
        check_addr("rt_addr", rt_use ? m_held[24:20] : 5'd0, rt_addr);
        check_bit("req_rs", rs_use, req_rs);
        check_bit("req_rt", rt_use, req_rt);
        check_word("imm", exp_imm, imm);
        check_word("base", exp_base, base);
    endtask

    //////////////////////////////
    // stimulus

    // mostly legal opcodes, with funct fields steered toward the special cases
    function automatic logic [31:0] random_instr();
        logic [31:0] w;
        w = $urandom;
        case ($urandom_range(11))
            0:  w[6:0] = decode_pkg::opc_op;
            1:  w[6:0] = decode_pkg::opc_op_imm;
            2:  w[6:0] = decode_pkg::opc_auipc;
            3:  w[6:0] = decode_pkg::opc_jal;
            4:  w[6:0] = decode_pkg::opc_jalr;
            5:  w[6:0] = decode_pkg::opc_branch;
            6:  w[6:0] = decode_pkg::opc_lui;
            7:  w[6:0] = decode_pkg::opc_load;
            8:  w[6:0] = decode_pkg::opc_store;
            9:  w[6:0] = decode_pkg::opc_misc_mem;
            10: w[6:0] = decode_pkg::opc_system;
            // low bits other than 11 are never a base opcode
            default: w[1:0] = 2'($urandom_range(2));
        endcase
        if (w[6:0] == decode_pkg::opc_op) begin
            case ($urandom_range(3))
                0: w[31:25] = decode_pkg::funct7_base;
                1: w[31:25] = decode_pkg::funct7_alt;
                2: w[31:25] = decode_pkg::funct7_muldiv;
                default: w[31:25] = w[31:25];
            endcase
        end else if (w[6:0] == decode_pkg::opc_op_imm && w[14:12] == 3'd5) begin
            w[31:25] = ($urandom_range(1) == 1) ? decode_pkg::funct7_alt
                                                : decode_pkg::funct7_base;
        end else if (w[6:0] == decode_pkg::opc_system && $urandom_range(1) == 1) begin
            // ecall or ebreak
            w[14:12] = 3'd0;
            w[31:20] = 12'($urandom_range(1));
        end
        return w;
    endfunction

    initial begin
        void'($urandom(32'h81d6_8727));
        rst_n   = 1'b0;
        stall   = 1'b0;
        clear   = 1'b0;
        instr   = '0;
        pc      = '0;
        m_held  = '0;
        m_pc    = '0;
        m_valid = 1'b0;

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        check_outputs();
        rst_n = 1'b1;

        for (int n = 0; n < num_cycles; n++) begin
            // a stalled instruction stays on the inputs until it is taken
            if (!(stall && !clear)) begin
                instr = random_instr();
                pc    = xlen'($urandom & 32'hffff_fffc);
            end
            stall = ($urandom_range(4) == 0);
            clear = ($urandom_range(19) == 0);
            if (clear) begin
                m_held  = '0;
                m_pc    = '0;
                m_valid = 1'b0;
            end else if (!stall) begin
                m_held  = instr;
                m_pc    = pc;
                m_valid = 1'b1;
            end
            @(negedge clk);
            check_outputs();
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
decode_pkg.sv
instr_latch.sv
op_classify.sv
uop_encode.sv
operand_select.sv
decode_stage.sv
decode_chk.sv
tb_decode_stage.sv

//--- run.sh
#!/usr/bin/env bash
# build the decode stage testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f build.f --top-module tb_decode_stage -o tb_decode_stage; then
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/tb_decode_stage; then
    echo "simulation failed"
    exit 1
fi

echo "simulation finished cleanly"
exit 0
